// File: compile.f
+incdir+source
source/isa_pkg.sv
source/core_pkg.sv
source/issue_stage.sv
source/execute_cluster.sv
source/reorder_buffer.sv
source/commit_stage.sv
source/ooo_core.sv
verif/clock_gen.sv
verif/core_tb.sv

// File: Makefile
# Verilator build and run for the out-of-order core testbench

TOP := core_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP) -o $(TOP)

# the log decides pass or fail
run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -qx "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: verif/core_tb.sv
`timescale 1ns/100ps

`include "core_config.svh"

module core_tb;
	import isa_pkg::*;
	import core_pkg::*;

	// cycles any single wait may take
	localparam int WAIT_LIMIT = 1000;

	typedef struct packed {
		reg_idx_t rd;
		logic wr_en;
		word_t data;
	} expect_t;

	logic clock;
	logic reset;
	logic inst_valid;
	instr_t inst_word;
	logic inst_credit;
	logic commit_valid;
	reg_idx_t commit_rd;
	logic commit_wr_en;
	word_t commit_data;

	// sender and checker bookkeeping
	int sent_count;
	int returned_count;
	int min_credits;
	int check_count;
	int value_errors;
	int other_errors;
	string test_name;
	instr_t sent_q [$];
	word_t model_regs [`NUM_REGS];
	expect_t commit_expect;

	clock_gen clock_gen_i (
		.clock(clock),
		.reset(reset)
	);

	ooo_core dut_i (
		.clock(clock),
		.reset(reset),
		.inst_valid(inst_valid),
		.inst_word(inst_word),
		.inst_credit(inst_credit),
		.commit_valid(commit_valid),
		.commit_rd(commit_rd),
		.commit_wr_en(commit_wr_en),
		.commit_data(commit_data)
	);

	////////////////////
	// instruction encoding
	////////////////////

	function automatic instr_t reg_op(logic [6:0] f7, logic [2:0] f3,
		reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
		instr_t ins;
		ins.r.funct7 = f7;
		ins.r.rs2 = rs2;
		ins.r.rs1 = rs1;
		ins.r.funct3 = funct3_e'(f3);
		ins.r.rd = rd;
		ins.r.opcode = OPC_OP;
		return ins;
	endfunction

	function automatic instr_t imm_op(logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1,
		logic [11:0] imm);
		instr_t ins;
		ins.i.imm = imm;
		ins.i.rs1 = rs1;
		ins.i.funct3 = funct3_e'(f3);
		ins.i.rd = rd;
		ins.i.opcode = OPC_OP_IMM;
		return ins;
	endfunction

	////////////////////
	// reference model
	////////////////////

	// runs one instruction in program order on the model registers
	function automatic expect_t expected_result(instr_t ins);
		logic [31:0] w;
		logic [6:0] opcode;
		logic [2:0] f3;
		logic [6:0] f7;
		word_t a;
		word_t b;
		word_t imm;
		word_t res;
		logic supported;
		expect_t result;
		w = ins;
		opcode = w[6:0];
		f3 = w[14:12];
		f7 = w[31:25];
		a = model_regs[w[19:15]];
		b = model_regs[w[24:20]];
		imm = {{20{w[31]}}, w[31:20]};
		res = '0;
		supported = 1'b1;
		if (opcode == 7'h33 && f7 == 7'h01 && f3 == 3'b000) begin
			res = a * b;
		end else if (opcode == 7'h33 && f7 == 7'h20 && f3 == 3'b000) begin
			res = a - b;
		end else if (opcode == 7'h33 && f7 == 7'h00) begin
			case (f3)
				3'b000: res = a + b;
				3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				3'b100: res = a ^ b;
				3'b110: res = a | b;
				3'b111: res = a & b;
				default: supported = 1'b0;
			endcase
		end else if (opcode == 7'h13) begin
			// no SLTI or shifts
			case (f3)
				3'b000: res = a + imm;
				3'b100: res = a ^ imm;
				3'b110: res = a | imm;
				3'b111: res = a & imm;
				default: supported = 1'b0;
			endcase
		end else begin
			supported = 1'b0;
		end
		result.rd = w[11:7];
		result.wr_en = supported && (w[11:7] != 5'd0);
		result.data = res;
		// x0 never written
		if (result.wr_en) begin
			model_regs[w[11:7]] = res;
		end
		return result;
	endfunction

	////////////////////
	// checks and limits
	////////////////////

	task automatic check_value(string what, word_t expected, word_t actual);
		check_count++;
		assert (actual === expected) else begin
			value_errors++;
			$display("Error %s %s: expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic stop_on_timeout(string what);
		$display("Timeout in %s: %s", test_name, what);
		$display("checks %0d, value errors %0d, other errors %0d", check_count,
			value_errors, other_errors + 1);
		$display("TB FAILED");
		$finish;
	endtask

	// returned input credits
	always @(posedge clock) begin
		if (!reset && inst_credit) begin
			returned_count++;
			assert (returned_count <= sent_count) else begin
				other_errors++;
				$display("input credits rose above the queue depth in %s", test_name);
			end
		end
	end

	// one expected result per commit, in program order
	always @(posedge clock) begin
		if (!reset && commit_valid) begin
			assert (sent_q.size() != 0) else begin
				other_errors++;
				$display("commit reported with no instruction outstanding in %s", test_name);
			end
			if (sent_q.size() != 0) begin
				commit_expect = expected_result(sent_q.pop_front());
				check_value("commit_rd", word_t'(commit_expect.rd), word_t'(commit_rd));
				check_value("commit_wr_en", word_t'(commit_expect.wr_en),
					word_t'(commit_wr_en));
				if (commit_expect.wr_en) begin
					check_value("commit_data", commit_expect.data, commit_data);
				end
			end
		end
	end

	////////////////////
	// stimulus
	////////////////////

	// called on a falling edge, spends one credit
	task automatic send_inst(instr_t ins);
		int waited;
		waited = 0;
		while (sent_count - returned_count >= `IQ_DEPTH) begin
			@(negedge clock);
			waited++;
			if (waited > WAIT_LIMIT) begin
				stop_on_timeout("no input credit came back");
			end
		end
		inst_valid = 1'b1;
		inst_word = ins;
		sent_count++;
		sent_q.push_back(ins);
		if (`IQ_DEPTH - (sent_count - returned_count) < min_credits) begin
			min_credits = `IQ_DEPTH - (sent_count - returned_count);
		end
		@(negedge clock);
		inst_valid = 1'b0;
	endtask

	task automatic drain_core();
		int waited;
		waited = 0;
		while (sent_q.size() != 0) begin
			@(negedge clock);
			waited++;
			if (waited > WAIT_LIMIT) begin
				stop_on_timeout("instructions stopped committing");
			end
		end
	endtask

	task automatic independent_alu();
		test_name = "independent_alu";
		// seed registers from x0
		send_inst(imm_op(3'b000, 5'd1, 5'd0, 12'd5));
		send_inst(imm_op(3'b000, 5'd2, 5'd0, 12'hffd));
		send_inst(imm_op(3'b110, 5'd3, 5'd0, 12'h7ff));
		send_inst(imm_op(3'b100, 5'd4, 5'd0, 12'h555));
		send_inst(imm_op(3'b111, 5'd5, 5'd0, 12'h0f0));
		send_inst(imm_op(3'b000, 5'd6, 5'd0, 12'h801));
		drain_core();
		send_inst(reg_op(7'h00, 3'b000, 5'd10, 5'd1, 5'd2));
		send_inst(reg_op(7'h20, 3'b000, 5'd11, 5'd3, 5'd4));
		send_inst(reg_op(7'h00, 3'b111, 5'd12, 5'd4, 5'd3));
		send_inst(reg_op(7'h00, 3'b110, 5'd13, 5'd1, 5'd6));
		send_inst(reg_op(7'h00, 3'b100, 5'd14, 5'd6, 5'd4));
		send_inst(reg_op(7'h00, 3'b010, 5'd15, 5'd6, 5'd2));
		send_inst(imm_op(3'b111, 5'd7, 5'd3, 12'h0ff));
		send_inst(imm_op(3'b110, 5'd8, 5'd2, 12'h00f));
		drain_core();
	endtask

	task automatic mul_overtake();
		test_name = "mul_overtake";
		// the ALU ops finish first, commits stay in order
		send_inst(reg_op(7'h01, 3'b000, 5'd16, 5'd1, 5'd2));
		send_inst(imm_op(3'b000, 5'd17, 5'd3, 12'd1));
		send_inst(reg_op(7'h00, 3'b100, 5'd18, 5'd4, 5'd5));
		send_inst(reg_op(7'h00, 3'b110, 5'd19, 5'd5, 5'd6));
		drain_core();
	endtask

	task automatic raw_chains();
		test_name = "raw_chains";
		send_inst(reg_op(7'h01, 3'b000, 5'd20, 5'd1, 5'd3));
		send_inst(reg_op(7'h00, 3'b000, 5'd21, 5'd20, 5'd1));
		send_inst(reg_op(7'h01, 3'b000, 5'd22, 5'd21, 5'd21));
		send_inst(reg_op(7'h20, 3'b000, 5'd23, 5'd22, 5'd20));
		send_inst(reg_op(7'h00, 3'b010, 5'd24, 5'd23, 5'd2));
		send_inst(imm_op(3'b000, 5'd25, 5'd24, 12'd100));
		// write after write on x25
		send_inst(reg_op(7'h01, 3'b000, 5'd25, 5'd25, 5'd25));
		send_inst(reg_op(7'h00, 3'b111, 5'd26, 5'd25, 5'd22));
		drain_core();
	endtask

	task automatic mul_flood();
		test_name = "mul_flood";
		min_credits = `IQ_DEPTH;
		send_inst(imm_op(3'b000, 5'd27, 5'd0, 12'd3));
		// dependent chain stalls issue and empties the credits
		for (int n = 0; n < 12; n++) begin
			send_inst(reg_op(7'h01, 3'b000, 5'd27, 5'd27, 5'd1));
		end
		for (int n = 0; n < 12; n++) begin
			send_inst(reg_op(7'h01, 3'b000, reg_idx_t'(8 + n), reg_idx_t'(1 + n % 6),
				reg_idx_t'(6 - n % 6)));
		end
		drain_core();
		check_value("credits returned", word_t'(sent_count), word_t'(returned_count));
		check_value("credits held", word_t'(`IQ_DEPTH),
			word_t'(`IQ_DEPTH - (sent_count - returned_count)));
		check_value("lowest credit count", 32'd0, word_t'(min_credits));
	endtask

	task automatic x0_and_illegal();
		test_name = "x0_and_illegal";
		send_inst(imm_op(3'b000, 5'd0, 5'd1, 12'd9));
		send_inst(reg_op(7'h00, 3'b000, 5'd0, 5'd1, 5'd2));
		send_inst(reg_op(7'h01, 3'b000, 5'd0, 5'd1, 5'd1));
		// ecall, slli x1, lw x1, sltu and mulh
		send_inst(instr_t'(32'h0000_0073));
		send_inst(instr_t'(32'h0020_9093));
		send_inst(instr_t'(32'h0000_a083));
		send_inst(reg_op(7'h00, 3'b011, 5'd7, 5'd1, 5'd2));
		send_inst(reg_op(7'h01, 3'b001, 5'd8, 5'd1, 5'd2));
		// x0 still reads zero, x1 untouched
		send_inst(imm_op(3'b000, 5'd29, 5'd0, 12'd0));
		send_inst(reg_op(7'h00, 3'b000, 5'd30, 5'd0, 5'd0));
		send_inst(reg_op(7'h00, 3'b110, 5'd31, 5'd0, 5'd1));
		drain_core();
	endtask

	function automatic instr_t random_inst();
		int kind;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		logic [11:0] imm;
		kind = $urandom_range(0, 10);
		rd = reg_idx_t'($urandom_range(0, 15));
		rs1 = reg_idx_t'($urandom_range(0, 15));
		rs2 = reg_idx_t'($urandom_range(0, 15));
		imm = 12'($urandom());
		case (kind)
			0: return reg_op(7'h00, 3'b000, rd, rs1, rs2);
			1: return reg_op(7'h20, 3'b000, rd, rs1, rs2);
			2: return reg_op(7'h00, 3'b111, rd, rs1, rs2);
			3: return reg_op(7'h00, 3'b110, rd, rs1, rs2);
			4: return reg_op(7'h00, 3'b100, rd, rs1, rs2);
			5: return reg_op(7'h00, 3'b010, rd, rs1, rs2);
			6: return reg_op(7'h01, 3'b000, rd, rs1, rs2);
			7: return imm_op(3'b000, rd, rs1, imm);
			8: return imm_op(3'b111, rd, rs1, imm);
			9: return imm_op(3'b110, rd, rs1, imm);
			default: return imm_op(3'b100, rd, rs1, imm);
		endcase
	endfunction

	task automatic random_stream();
		test_name = "random_stream";
		for (int n = 0; n < 200; n++) begin
			send_inst(random_inst());
			repeat ($urandom_range(0, 2)) begin
				@(negedge clock);
			end
		end
		drain_core();
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial begin
		int seed;
		int waited;
		seed = 63;
		void'($urandom(seed));
		inst_valid = 1'b0;
		inst_word = '0;
		sent_count = 0;
		returned_count = 0;
		min_credits = `IQ_DEPTH;
		check_count = 0;
		value_errors = 0;
		other_errors = 0;
		test_name = "reset";
		for (int r = 0; r < `NUM_REGS; r++) begin
			model_regs[r] = '0;
		end

		// leave reset on a falling edge
		waited = 0;
		@(posedge clock);
		while (reset !== 1'b0) begin
			@(posedge clock);
			waited++;
			if (waited > WAIT_LIMIT) begin
				stop_on_timeout("reset never released");
			end
		end
		@(negedge clock);
		check_value("inst_credit", 32'd0, word_t'(inst_credit));
		check_value("commit_valid", 32'd0, word_t'(commit_valid));

		independent_alu();
		mul_overtake();
		raw_chains();
		mul_flood();
		x0_and_illegal();
		random_stream();

		$display("checks %0d, value errors %0d, other errors %0d", check_count,
			value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// File: verif/clock_gen.sv
`timescale 1ns/100ps

module clock_gen #(
	parameter int HALF_PERIOD = 4,
	parameter int RESET_CYCLES = 2
) (
	output logic clock,
	output logic reset
);

	// free running, 8 ns period
	initial begin
		clock = 1'b0;
		forever begin
			#(HALF_PERIOD) clock = ~clock;
		end
	end

	// held over the first rising edges, released on a falling edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) begin
			@(posedge clock);
		end
		@(negedge clock);
		reset = 1'b0;
	end

endmodule

// File: source/ooo_core.sv
`timescale 1ns/100ps

module ooo_core (
	input  logic              clock,
	input  logic              reset,
	input  logic              inst_valid,
	input  isa_pkg::instr_t   inst_word,
	output logic              inst_credit,
	output logic              commit_valid,
	output core_pkg::reg_idx_t commit_rd,
	output logic              commit_wr_en,
	output core_pkg::word_t   commit_data
);
	import core_pkg::*;

	// operand read path
	reg_idx_t rs1_idx;
	reg_idx_t rs2_idx;
	word_t rs1_value;
	word_t rs2_value;

	// dispatch bundle
	logic dispatch_valid;
	unit_e dispatch_unit;
	alu_op_e dispatch_op;
	word_t dispatch_a;
	word_t dispatch_b;
	reg_idx_t dispatch_rd;
	logic dispatch_wr_en;
	rob_tag_t alloc_tag;

	// result ports into the ROB
	logic alu_valid;
	rob_tag_t alu_tag;
	word_t alu_value;
	logic mul_valid;
	rob_tag_t mul_tag;
	word_t mul_value;

	// head and retire
	logic head_ready;
	reg_idx_t head_rd;
	logic head_wr_en;
	word_t head_value;
	logic retire;
	reg_idx_t retire_rd;
	logic retire_wr_en;

	////////////////////
	// issue
	////////////////////

	issue_stage issue_i (
		.clock(clock),
		.reset(reset),
		.inst_valid(inst_valid),
		.inst_word(inst_word),
		.rs1_value(rs1_value),
		.rs2_value(rs2_value),
		.retire(retire),
		.retire_rd(retire_rd),
		.retire_wr_en(retire_wr_en),
		.inst_credit(inst_credit),
		.rs1_idx(rs1_idx),
		.rs2_idx(rs2_idx),
		.dispatch_valid(dispatch_valid),
		.dispatch_unit(dispatch_unit),
		.dispatch_op(dispatch_op),
		.dispatch_a(dispatch_a),
		.dispatch_b(dispatch_b),
		.dispatch_rd(dispatch_rd),
		.dispatch_wr_en(dispatch_wr_en)
	);

	////////////////////
	// execute
	////////////////////

	execute_cluster execute_i (
		.clock(clock),
		.reset(reset),
		.dispatch_valid(dispatch_valid),
		.dispatch_unit(dispatch_unit),
		.dispatch_op(dispatch_op),
		.dispatch_a(dispatch_a),
		.dispatch_b(dispatch_b),
		.alloc_tag(alloc_tag),
		.alu_valid(alu_valid),
		.alu_tag(alu_tag),
		.alu_value(alu_value),
		.mul_valid(mul_valid),
		.mul_tag(mul_tag),
		.mul_value(mul_value)
	);

	////////////////////
	// reorder buffer
	////////////////////

	reorder_buffer rob_i (
		.clock(clock),
		.reset(reset),
		.dispatch_valid(dispatch_valid),
		.dispatch_unit(dispatch_unit),
		.dispatch_rd(dispatch_rd),
		.dispatch_wr_en(dispatch_wr_en),
		.alu_valid(alu_valid),
		.alu_tag(alu_tag),
		.alu_value(alu_value),
		.mul_valid(mul_valid),
		.mul_tag(mul_tag),
		.mul_value(mul_value),
		.retire(retire),
		.alloc_tag(alloc_tag),
		.head_ready(head_ready),
		.head_rd(head_rd),
		.head_wr_en(head_wr_en),
		.head_value(head_value)
	);

	////////////////////
	// commit
	////////////////////

	commit_stage commit_i (
		.clock(clock),
		.reset(reset),
		.head_ready(head_ready),
		.head_rd(head_rd),
		.head_wr_en(head_wr_en),
		.head_value(head_value),
		.rs1_idx(rs1_idx),
		.rs2_idx(rs2_idx),
		.retire(retire),
		.retire_rd(retire_rd),
		.retire_wr_en(retire_wr_en),
		.rs1_value(rs1_value),
		.rs2_value(rs2_value),
		.commit_valid(commit_valid),
		.commit_rd(commit_rd),
		.commit_wr_en(commit_wr_en),
		.commit_data(commit_data)
	);

endmodule

// File: source/commit_stage.sv
`timescale 1ns/100ps

`include "core_config.svh"

module commit_stage (
	input  logic              clock,
	input  logic              reset,
	input  logic              head_ready,
	input  core_pkg::reg_idx_t head_rd,
	input  logic              head_wr_en,
	input  core_pkg::word_t   head_value,
	input  core_pkg::reg_idx_t rs1_idx,
	input  core_pkg::reg_idx_t rs2_idx,
	output logic              retire,
	output core_pkg::reg_idx_t retire_rd,
	output logic              retire_wr_en,
	output core_pkg::word_t   rs1_value,
	output core_pkg::word_t   rs2_value,
	output logic              commit_valid,
	output core_pkg::reg_idx_t commit_rd,
	output logic              commit_wr_en,
	output core_pkg::word_t   commit_data
);
	import core_pkg::*;

	// architectural state
	word_t arch_regs [`NUM_REGS];

	// in order, one per cycle, whenever the head is done
	assign retire = head_ready;
	assign retire_rd = head_rd;
	assign retire_wr_en = head_wr_en;

	// wr_en is already low for x0, so entry 0 stays zero
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				arch_regs[i] <= '0;
			end
		end else if (retire && head_wr_en) begin
			arch_regs[head_rd] <= head_value;
		end
	end

	// operand reads for issue
	assign rs1_value = arch_regs[rs1_idx];
	assign rs2_value = arch_regs[rs2_idx];

	////////////////////
	// commit report
	////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			commit_valid <= 1'b0;
		end else begin
			commit_valid <= retire;
		end
	end

	always_ff @(posedge clock) begin
		commit_rd <= head_rd;
		commit_wr_en <= head_wr_en;
		commit_data <= head_value;
	end

endmodule

// File: source/reorder_buffer.sv
`timescale 1ns/100ps

`include "core_config.svh"

module reorder_buffer (
	input  logic              clock,
	input  logic              reset,
	input  logic              dispatch_valid,
	input  core_pkg::unit_e   dispatch_unit,
	input  core_pkg::reg_idx_t dispatch_rd,
	input  logic              dispatch_wr_en,
	input  logic              alu_valid,
	input  core_pkg::rob_tag_t alu_tag,
	input  core_pkg::word_t   alu_value,
	input  logic              mul_valid,
	input  core_pkg::rob_tag_t mul_tag,
	input  core_pkg::word_t   mul_value,
	input  logic              retire,
	output core_pkg::rob_tag_t alloc_tag,
	output logic              head_ready,
	output core_pkg::reg_idx_t head_rd,
	output logic              head_wr_en,
	output core_pkg::word_t   head_value
);
	import core_pkg::*;

	// ROB_DEPTH is 2**ROB_TAG_W, pointers wrap naturally
	rob_tag_t head;
	rob_tag_t tail;

	logic [`ROB_DEPTH-1:0] entry_ready;
	reg_idx_t entry_rd [`ROB_DEPTH];
	logic entry_wr_en [`ROB_DEPTH];
	word_t entry_value [`ROB_DEPTH];

	////////////////////
	// pointers and ready bits
	////////////////////

	// issue holds credits, so tail never runs into an occupied head
	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			entry_ready <= '0;
		end else begin
			if (retire) begin
				entry_ready[head] <= 1'b0;
				head <= head + rob_tag_t'(1);
			end
			if (dispatch_valid) begin
				// no-result entries are done at allocation
				entry_ready[tail] <= (dispatch_unit == UNIT_NONE);
				tail <= tail + rob_tag_t'(1);
			end
			// both result ports land in the same cycle if needed
			if (alu_valid) begin
				entry_ready[alu_tag] <= 1'b1;
			end
			if (mul_valid) begin
				entry_ready[mul_tag] <= 1'b1;
			end
		end
	end

	////////////////////
	// entry payload
	////////////////////

	always_ff @(posedge clock) begin
		if (dispatch_valid) begin
			entry_rd[tail] <= dispatch_rd;
			entry_wr_en[tail] <= dispatch_wr_en;
			// zero until a result arrives
			entry_value[tail] <= '0;
		end
		if (alu_valid) begin
			entry_value[alu_tag] <= alu_value;
		end
		if (mul_valid) begin
			entry_value[mul_tag] <= mul_value;
		end
	end

	// head readout for commit
	assign alloc_tag = tail;
	assign head_ready = entry_ready[head];
	assign head_rd = entry_rd[head];
	assign head_wr_en = entry_wr_en[head];
	assign head_value = entry_value[head];

endmodule

// File: source/execute_cluster.sv
`timescale 1ns/100ps

`include "core_config.svh"

module execute_cluster (
	input  logic              clock,
	input  logic              reset,
	input  logic              dispatch_valid,
	input  core_pkg::unit_e   dispatch_unit,
	input  core_pkg::alu_op_e dispatch_op,
	input  core_pkg::word_t   dispatch_a,
	input  core_pkg::word_t   dispatch_b,
	input  core_pkg::rob_tag_t alloc_tag,
	output logic              alu_valid,
	output core_pkg::rob_tag_t alu_tag,
	output core_pkg::word_t   alu_value,
	output logic              mul_valid,
	output core_pkg::rob_tag_t mul_tag,
	output core_pkg::word_t   mul_value
);
	import core_pkg::*;

	word_t alu_result;
	word_t product;

	// mul pipeline, stage 0 loads at dispatch
	logic [`MUL_LATENCY-1:0] mul_vld_q;
	rob_tag_t mul_tag_q [`MUL_LATENCY];
	word_t mul_value_q [`MUL_LATENCY];

	////////////////////
	// alu
	////////////////////

	always_comb begin
		case (dispatch_op)
			ALU_ADD: alu_result = dispatch_a + dispatch_b;
			ALU_SUB: alu_result = dispatch_a - dispatch_b;
			ALU_AND: alu_result = dispatch_a & dispatch_b;
			ALU_OR: alu_result = dispatch_a | dispatch_b;
			ALU_XOR: alu_result = dispatch_a ^ dispatch_b;
			// signed compare, 0 or 1
			ALU_SLT: alu_result = {{(`XLEN-1){1'b0}}, $signed(dispatch_a) < $signed(dispatch_b)};
			default: alu_result = dispatch_a + dispatch_b;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			alu_valid <= 1'b0;
		end else begin
			alu_valid <= dispatch_valid && (dispatch_unit == UNIT_ALU);
		end
	end

	always_ff @(posedge clock) begin
		alu_tag <= alloc_tag;
		alu_value <= alu_result;
	end

	////////////////////
	// multiplier
	////////////////////

	// low word only, MUL semantics
	assign product = dispatch_a * dispatch_b;

	always_ff @(posedge clock) begin
		if (reset) begin
			mul_vld_q <= '0;
		end else begin
			mul_vld_q <= {mul_vld_q[`MUL_LATENCY-2:0], dispatch_valid && (dispatch_unit == UNIT_MUL)};
		end
	end

	// one issue per cycle, so several multiplies can be in flight
	always_ff @(posedge clock) begin
		mul_tag_q[0] <= alloc_tag;
		mul_value_q[0] <= product;
		for (int i = 1; i < `MUL_LATENCY; i++) begin
			mul_tag_q[i] <= mul_tag_q[i-1];
			mul_value_q[i] <= mul_value_q[i-1];
		end
	end

	assign mul_valid = mul_vld_q[`MUL_LATENCY-1];
	assign mul_tag = mul_tag_q[`MUL_LATENCY-1];
	assign mul_value = mul_value_q[`MUL_LATENCY-1];

endmodule

// File: source/issue_stage.sv
`timescale 1ns/100ps

`include "core_config.svh"

module issue_stage (
	input  logic              clock,
	input  logic              reset,
	input  logic              inst_valid,
	input  isa_pkg::instr_t   inst_word,
	input  core_pkg::word_t   rs1_value,
	input  core_pkg::word_t   rs2_value,
	input  logic              retire,
	input  core_pkg::reg_idx_t retire_rd,
	input  logic              retire_wr_en,
	output logic              inst_credit,
	output core_pkg::reg_idx_t rs1_idx,
	output core_pkg::reg_idx_t rs2_idx,
	output logic              dispatch_valid,
	output core_pkg::unit_e   dispatch_unit,
	output core_pkg::alu_op_e dispatch_op,
	output core_pkg::word_t   dispatch_a,
	output core_pkg::word_t   dispatch_b,
	output core_pkg::reg_idx_t dispatch_rd,
	output logic              dispatch_wr_en
);
	import isa_pkg::*;
	import core_pkg::*;

	// depth is a power of two, pointers wrap on their own
	localparam int IQ_PTR_W = $clog2(`IQ_DEPTH);

	typedef logic [IQ_PTR_W-1:0] iq_ptr_t;
	typedef logic [IQ_PTR_W:0] iq_count_t;
	typedef logic [`ROB_TAG_W:0] credit_t;

	instr_t iq_mem [`IQ_DEPTH];
	iq_ptr_t iq_head;
	iq_ptr_t iq_tail;
	iq_count_t iq_count;
	instr_t head_inst;

	credit_t rob_credits;
	logic [`NUM_REGS-1:0] pending;

	unit_e dec_unit;
	alu_op_e dec_op;
	logic dec_reg_form;
	logic dec_real;
	logic dec_wr_en;
	logic stall;
	word_t imm_ext;

	////////////////////
	// instruction queue
	////////////////////

	// payload only, occupancy tracked below
	always_ff @(posedge clock) begin
		if (inst_valid) begin
			iq_mem[iq_tail] <= inst_word;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			iq_head <= '0;
			iq_tail <= '0;
			iq_count <= '0;
		end else begin
			// sender never pushes without a credit, so no full check
			if (inst_valid) begin
				iq_tail <= iq_tail + iq_ptr_t'(1);
			end
			if (dispatch_valid) begin
				iq_head <= iq_head + iq_ptr_t'(1);
			end
			case ({inst_valid, dispatch_valid})
				2'b10: iq_count <= iq_count + iq_count_t'(1);
				2'b01: iq_count <= iq_count - iq_count_t'(1);
				default: iq_count <= iq_count;
			endcase
		end
	end

	assign head_inst = iq_mem[iq_head];

	////////////////////
	// decode
	////////////////////

	always_comb begin
		dec_unit = UNIT_NONE;
		dec_op = ALU_ADD;
		dec_reg_form = 1'b0;
		case (head_inst.r.opcode)
			OPC_OP: begin
				dec_reg_form = 1'b1;
				if (head_inst.r.funct7 == FUNCT7_MULDIV) begin
					// only MUL from the M extension
					if (head_inst.r.funct3 == F3_ADD_SUB) begin
						dec_unit = UNIT_MUL;
					end
				end else if (head_inst.r.funct7 == FUNCT7_ALT) begin
					if (head_inst.r.funct3 == F3_ADD_SUB) begin
						dec_unit = UNIT_ALU;
						dec_op = ALU_SUB;
					end
				end else if (head_inst.r.funct7 == '0) begin
					dec_unit = UNIT_ALU;
					case (head_inst.r.funct3)
						F3_ADD_SUB: dec_op = ALU_ADD;
						F3_SLT: dec_op = ALU_SLT;
						F3_XOR: dec_op = ALU_XOR;
						F3_OR: dec_op = ALU_OR;
						F3_AND: dec_op = ALU_AND;
						default: dec_unit = UNIT_NONE;
					endcase
				end
			end
			OPC_OP_IMM: begin
				// no SLTI in the subset
				dec_unit = UNIT_ALU;
				case (head_inst.i.funct3)
					F3_ADD_SUB: dec_op = ALU_ADD;
					F3_XOR: dec_op = ALU_XOR;
					F3_OR: dec_op = ALU_OR;
					F3_AND: dec_op = ALU_AND;
					default: dec_unit = UNIT_NONE;
				endcase
			end
			default: dec_unit = UNIT_NONE;
		endcase
	end

	// anything unsupported reads nothing and writes nothing
	assign dec_real = (dec_unit != UNIT_NONE);
	assign dec_wr_en = dec_real && (head_inst.r.rd != '0);
	assign imm_ext = {{(`XLEN-12){head_inst.i.imm[11]}}, head_inst.i.imm};

	// rs1 and rd sit at the same bits in both views
	assign rs1_idx = head_inst.r.rs1;
	assign rs2_idx = head_inst.r.rs2;

	////////////////////
	// scoreboard and ROB credits
	////////////////////

	// any pending source or destination holds the head
	assign stall = (dec_real && pending[rs1_idx])
		|| (dec_real && dec_reg_form && pending[rs2_idx])
		|| (dec_wr_en && pending[head_inst.r.rd]);

	assign dispatch_valid = (iq_count != '0) && (rob_credits != '0) && !stall;
	assign inst_credit = dispatch_valid;

	always_ff @(posedge clock) begin
		if (reset) begin
			pending <= '0;
		end else begin
			if (retire && retire_wr_en) begin
				pending[retire_rd] <= 1'b0;
			end
			// rd was not pending, so no clash with the clear above
			if (dispatch_valid && dispatch_wr_en) begin
				pending[dispatch_rd] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			rob_credits <= credit_t'(`ROB_DEPTH);
		end else begin
			case ({dispatch_valid, retire})
				2'b10: rob_credits <= rob_credits - credit_t'(1);
				2'b01: rob_credits <= rob_credits + credit_t'(1);
				default: rob_credits <= rob_credits;
			endcase
		end
	end

	// dispatch bundle to execute and ROB
	assign dispatch_unit = dec_unit;
	assign dispatch_op = dec_op;
	assign dispatch_a = rs1_value;
	assign dispatch_b = dec_reg_form ? rs2_value : imm_ext;
	assign dispatch_rd = head_inst.r.rd;
	assign dispatch_wr_en = dec_wr_en;

endmodule

// File: source/core_pkg.sv
`include "core_config.svh"

package core_pkg;

	////////////////////
	// basic words
	////////////////////

	typedef logic [`XLEN-1:0] word_t;
	typedef logic [`REG_IDX_W-1:0] reg_idx_t;

	// index of a reorder buffer entry
	typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

	////////////////////
	// execution control
	////////////////////

	// UNIT_NONE retires straight from the ROB, no result
	typedef enum logic [1:0] {
		UNIT_NONE = 2'd0,
		UNIT_ALU  = 2'd1,
		UNIT_MUL  = 2'd2
	} unit_e;

	// single-cycle ALU functions
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLT = 3'd5
	} alu_op_e;

endpackage

// File: source/isa_pkg.sv
package isa_pkg;

	////////////////////
	// opcodes and function codes
	////////////////////

	// only the integer ALU major opcodes are decoded
	typedef enum logic [6:0] {
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011
	} opcode_e;

	// funct3 values shared by register and immediate forms
	typedef enum logic [2:0] {
		F3_ADD_SUB = 3'b000,
		F3_SLT     = 3'b010,
		F3_XOR     = 3'b100,
		F3_OR      = 3'b110,
		F3_AND     = 3'b111
	} funct3_e;

	// funct7 selecting SUB and the M extension
	localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;
	localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

	////////////////////
	// instruction word
	////////////////////

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		funct3_e    funct3;
		logic [4:0] rd;
		opcode_e    opcode;
	} r_type_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		funct3_e     funct3;
		logic [4:0]  rd;
		opcode_e     opcode;
	} i_type_t;

	// same 32 bits, view chosen by opcode
	typedef union packed {
		r_type_t r;
		i_type_t i;
	} instr_t;

endpackage

// File: source/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// datapath
`define XLEN 32

// architectural register file
`define NUM_REGS 32
`define REG_IDX_W 5

// instruction queue, one input credit per entry
`define IQ_DEPTH 4

// reorder buffer, tag indexes an entry
`define ROB_DEPTH 8
`define ROB_TAG_W 3

// multiplier, cycles from dispatch to result
`define MUL_LATENCY 3

`endif
